// File: bgpu_cfg.svh
/* BGPU issue stage configuration
   Sizes shared by the package and the issue stage modules */

`ifndef BGPU_CFG_SVH
`define BGPU_CFG_SVH

// ##############################
// Base sizes
// ##############################

// Warps per compute unit
`define BGPU_NUM_WARPS      4
// In-flight instructions per warp
`define BGPU_NUM_TAGS       4
// Buffered instructions per warp
`define BGPU_WAIT_BUF_DEPTH 4
`define BGPU_PC_WIDTH       16
// Threads per warp, also the active mask width
`define BGPU_WARP_WIDTH     8
`define BGPU_REG_IDX_WIDTH  6
// Operands per instruction
`define BGPU_OPERANDS       2
// Opcode width
`define BGPU_INST_WIDTH     8

// Derived, keep in sync with the base sizes
`define BGPU_NUM_REGS       (1 << `BGPU_REG_IDX_WIDTH)
`define BGPU_WID_WIDTH      ($clog2(`BGPU_NUM_WARPS))
`define BGPU_TAG_WIDTH      ($clog2(`BGPU_NUM_TAGS))

`endif

// File: bgpu_pkg.sv
/* BGPU issue stage types
   Scalar types and packed structs passed between fetch, decode and issue */

`include "bgpu_cfg.svh"

package bgpu_pkg;

    // ##############################
    // Scalar types
    // ##############################

    typedef logic [`BGPU_WID_WIDTH-1:0]     wid_t;
    typedef logic [`BGPU_TAG_WIDTH-1:0]     tag_t;
    typedef logic [`BGPU_REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [`BGPU_PC_WIDTH-1:0]      pc_t;
    typedef logic [`BGPU_WARP_WIDTH-1:0]    act_mask_t;
    typedef logic [`BGPU_INST_WIDTH-1:0]    bgpu_inst_t;

    // Wait buffer fill level, 0 up to the full depth
    typedef logic [$clog2(`BGPU_WAIT_BUF_DEPTH+1)-1:0] buf_cnt_t;

    // ##############################
    // Structs
    // ##############################

    // Global instruction id
    // Tag in the upper field, warp in the lower one
    typedef struct packed {
        tag_t tag;
        wid_t wid;
    } iid_t;

    // Decoded instruction as written by the decoder
    typedef struct packed {
        pc_t                              pc;
        act_mask_t                        act_mask;
        bgpu_inst_t                       inst;
        reg_idx_t                         dst;
        logic [`BGPU_OPERANDS-1:0]        operands_required;
        reg_idx_t [`BGPU_OPERANDS-1:0]    operands;
    } dec_inst_t;

    // Offer of one warp towards the arbiter
    typedef struct packed {
        tag_t      tag;
        dec_inst_t dec;
    } disp_entry_t;

    // Issued instruction towards the operand collector
    typedef struct packed {
        iid_t      iid;
        dec_inst_t dec;
    } disp_inst_t;

endpackage

// File: issue_scoreboard.sv
/* Issue scoreboard
   Per-warp tag free list and busy bits of destination registers */

`timescale 1ns/1ps

`include "bgpu_cfg.svh"

module issue_scoreboard import bgpu_pkg::*; (
    input  logic                       clk_i,
    input  logic                       reset_i,

    // Allocation on issue
    input  logic                       alloc_i,
    input  reg_idx_t                   alloc_dst_i,
    output tag_t                       alloc_tag_o,
    output logic                       tag_avail_o,

    // Release on writeback
    input  logic                       release_i,
    input  tag_t                       release_tag_i,

    // One busy bit per register
    output logic [`BGPU_NUM_REGS-1:0]  busy_o
);

    localparam int unsigned NUM_TAGS = `BGPU_NUM_TAGS;

    // Tag state
    logic [NUM_TAGS-1:0] tag_free;
    // Destination held by each tag
    reg_idx_t            tag_dst [NUM_TAGS];
    logic [`BGPU_NUM_REGS-1:0] reg_busy;

    // ##############################
    // Free tag search
    // ##############################

    // Lowest free tag wins, so scan downwards
    always_comb begin
        alloc_tag_o = '0;
        for (int i = NUM_TAGS - 1; i >= 0; i--) begin
            if (tag_free[i]) begin
                alloc_tag_o = tag_t'(i);
            end
        end
    end

    assign tag_avail_o = |tag_free;
    assign busy_o      = reg_busy;

    // ##############################
    // State update
    // ##############################

    // Release first, alloc may then reclaim the same register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tag_free <= '1;
            reg_busy <= '0;
        end else begin
            if (release_i) begin
                tag_free[release_tag_i]          <= 1'b1;
                reg_busy[tag_dst[release_tag_i]] <= 1'b0;
            end
            if (alloc_i) begin
                tag_free[alloc_tag_o] <= 1'b0;
                reg_busy[alloc_dst_i] <= 1'b1;
            end
        end
    end

    // Destination per tag, only meaningful while the tag is taken
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            tag_dst[alloc_tag_o] <= alloc_dst_i;
        end
    end

    // Writeback must name a tag that is in flight
    assert property (@(posedge clk_i) disable iff (reset_i)
        release_i |-> !tag_free[release_tag_i]);

    // Issue only with a tag at hand
    assert property (@(posedge clk_i) disable iff (reset_i)
        alloc_i |-> tag_avail_o);

endmodule

// File: warp_dispatcher.sv
/* Warp dispatcher
   Slot reservation, age-ordered wait buffer and ready selection for one warp */

`timescale 1ns/1ps

`include "bgpu_cfg.svh"

module warp_dispatcher import bgpu_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,

    // Fetcher side
    input  logic        fe_handshake_i,
    output logic        space_avail_o,

    // Decoder side
    input  logic        dec_valid_i,
    output logic        dec_ready_o,
    input  dec_inst_t   dec_inst_i,

    // Arbiter side
    input  logic        grant_i,
    output logic        offer_valid_o,
    output disp_entry_t offer_o,

    // Writeback, tag already stripped of the warp index
    input  logic        eu_valid_i,
    input  tag_t        eu_tag_i
);

    localparam int unsigned DEPTH = `BGPU_WAIT_BUF_DEPTH;

    // Reservations not yet written by the decoder
    buf_cnt_t                   res_cnt;
    buf_cnt_t                   occ_cnt;
    buf_cnt_t                   wr_pos;
    logic                       dec_write;

    // Wait buffer, index 0 holds the oldest entry
    logic [DEPTH-1:0]           ent_valid;
    logic [DEPTH-1:0]           nxt_valid;
    logic [DEPTH-1:0]           ent_ready;
    dec_inst_t                  ent_data [DEPTH];
    dec_inst_t                  nxt_data [DEPTH];
    logic [$clog2(DEPTH)-1:0]   sel_idx;

    // Scoreboard view
    logic                       tag_avail;
    tag_t                       alloc_tag;
    logic [`BGPU_NUM_REGS-1:0]  reg_busy;

    // ##############################
    // Slot accounting
    // ##############################

    // Entries stay packed at the bottom, a popcount gives the fill level
    always_comb begin
        occ_cnt = '0;
        for (int i = 0; i < DEPTH; i++) begin
            occ_cnt = occ_cnt + buf_cnt_t'(ent_valid[i]);
        end
    end

    assign space_avail_o = (res_cnt + occ_cnt) != buf_cnt_t'(DEPTH);
    // A write always finds room once it holds a reservation
    assign dec_ready_o   = occ_cnt != buf_cnt_t'(DEPTH);
    assign dec_write     = dec_valid_i & dec_ready_o;

    // ##############################
    // Hazard check
    // ##############################

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ent_ready[i] = ent_valid[i] & tag_avail;
            // In-flight result on the destination
            if (reg_busy[ent_data[i].dst]) begin
                ent_ready[i] = 1'b0;
            end
            // In-flight result on a source
            for (int k = 0; k < `BGPU_OPERANDS; k++) begin
                if (ent_data[i].operands_required[k] && reg_busy[ent_data[i].operands[k]]) begin
                    ent_ready[i] = 1'b0;
                end
            end
            // Older buffered entries
            for (int j = 0; j < DEPTH; j++) begin
                if (j < i && ent_valid[j]) begin
                    // WAW
                    if (ent_data[j].dst == ent_data[i].dst) begin
                        ent_ready[i] = 1'b0;
                    end
                    for (int k = 0; k < `BGPU_OPERANDS; k++) begin
                        // RAW
                        if (ent_data[i].operands_required[k] &&
                            ent_data[i].operands[k] == ent_data[j].dst) begin
                            ent_ready[i] = 1'b0;
                        end
                        // WAR
                        if (ent_data[j].operands_required[k] &&
                            ent_data[j].operands[k] == ent_data[i].dst) begin
                            ent_ready[i] = 1'b0;
                        end
                    end
                end
            end
        end
    end

    // Oldest ready entry wins
    always_comb begin
        sel_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (ent_ready[i]) begin
                sel_idx = i[$clog2(DEPTH)-1:0];
            end
        end
    end

    assign offer_valid_o = |ent_ready;
    assign offer_o.tag   = alloc_tag;
    assign offer_o.dec   = ent_data[sel_idx];

    // ##############################
    // Buffer update
    // ##############################

    // Slot freed by a grant in the same cycle is reused
    assign wr_pos = occ_cnt - buf_cnt_t'(grant_i);

    always_comb begin
        nxt_valid = ent_valid;
        nxt_data  = ent_data;
        // Collapse above the granted entry, keeps age order
        for (int i = 0; i < DEPTH - 1; i++) begin
            if (grant_i && i >= int'(sel_idx)) begin
                nxt_valid[i] = ent_valid[i+1];
                nxt_data[i]  = ent_data[i+1];
            end
        end
        if (grant_i) begin
            nxt_valid[DEPTH-1] = 1'b0;
        end
        // New entry on top
        for (int i = 0; i < DEPTH; i++) begin
            if (dec_write && buf_cnt_t'(i) == wr_pos) begin
                nxt_valid[i] = 1'b1;
                nxt_data[i]  = dec_inst_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ent_valid <= '0;
            res_cnt   <= '0;
        end else begin
            ent_valid <= nxt_valid;
            res_cnt   <= res_cnt + buf_cnt_t'(fe_handshake_i) - buf_cnt_t'(dec_write);
        end
    end

    always_ff @(posedge clk_i) begin
        ent_data <= nxt_data;
    end

    issue_scoreboard i_scoreboard (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .alloc_i       (grant_i),
        .alloc_dst_i   (ent_data[sel_idx].dst),
        .alloc_tag_o   (alloc_tag),
        .tag_avail_o   (tag_avail),
        .release_i     (eu_valid_i),
        .release_tag_i (eu_tag_i),
        .busy_o        (reg_busy)
    );

    // Decoder writes only against an earlier reservation
    assert property (@(posedge clk_i) disable iff (reset_i)
        dec_valid_i |-> res_cnt != '0);

    // Arbiter grants only a warp that offers
    assert property (@(posedge clk_i) disable iff (reset_i)
        grant_i |-> offer_valid_o);

endmodule

// File: issue_rr_arbiter.sv
/* Round-robin issue arbiter
   Fair pick of one requesting warp, payload type set by parameter */

`timescale 1ns/1ps

`include "bgpu_cfg.svh"

module issue_rr_arbiter import bgpu_pkg::*; #(
    parameter type DATA_T = logic
) (
    input  logic                           clk_i,
    input  logic                           reset_i,

    // Requests from the warps
    input  logic [`BGPU_NUM_WARPS-1:0]     req_i,
    input  DATA_T [`BGPU_NUM_WARPS-1:0]    data_i,
    output logic [`BGPU_NUM_WARPS-1:0]     gnt_o,

    // Towards the consumer
    output logic                           valid_o,
    input  logic                           ready_i,
    output DATA_T                          data_o,
    output wid_t                           idx_o
);

    localparam int unsigned NUM_IN = `BGPU_NUM_WARPS;

    // First input to look at
    wid_t rr_ptr;
    wid_t sel_idx;
    logic found;
    logic fire;

    // ##############################
    // Selection
    // ##############################

    // Scan from the pointer, wrapping around
    always_comb begin
        wid_t cand;
        sel_idx = rr_ptr;
        found   = 1'b0;
        for (int off = 0; off < NUM_IN; off++) begin
            cand = wid_t'((int'(rr_ptr) + off) % NUM_IN);
            if (!found && req_i[cand]) begin
                found   = 1'b1;
                sel_idx = cand;
            end
        end
    end

    assign valid_o = found;
    assign idx_o   = sel_idx;
    assign data_o  = data_i[sel_idx];
    assign fire    = valid_o & ready_i;

    // Grant only on an accepted transfer
    always_comb begin
        gnt_o = '0;
        if (fire) begin
            gnt_o[sel_idx] = 1'b1;
        end
    end

    // ##############################
    // Pointer
    // ##############################

    // Move just past the winner, stalled offers keep their turn
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_ptr <= '0;
        end else if (fire) begin
            rr_ptr <= wid_t'((int'(sel_idx) + 1) % NUM_IN);
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o));

endmodule

// File: multi_warp_dispatcher.sv
/* Multi-warp dispatcher
   Issue stage top, one dispatcher per warp merged by a round-robin arbiter */

`timescale 1ns/1ps

`include "bgpu_cfg.svh"

module multi_warp_dispatcher import bgpu_pkg::*; (
    input  logic                          clk_i,
    input  logic                          reset_i,

    // Fetcher
    input  logic                          fe_handshake_i,
    input  wid_t                          fe_warp_id_i,
    output logic [`BGPU_NUM_WARPS-1:0]    ib_space_available_o,

    // Decoder
    input  logic                          dec_valid_i,
    input  wid_t                          dec_warp_id_i,
    input  dec_inst_t                     dec_inst_i,
    output logic                          ib_ready_o,

    // Operand collector
    output logic                          disp_valid_o,
    output disp_inst_t                    disp_o,
    input  logic                          opc_ready_i,

    // Execution unit writeback
    input  logic                          eu_valid_i,
    input  iid_t                          eu_tag_i
);

    localparam int unsigned NUM_WARPS = `BGPU_NUM_WARPS;

    // Per-warp strobes
    logic [NUM_WARPS-1:0]          fe_hs_warp;
    logic [NUM_WARPS-1:0]          dec_valid_warp;
    logic [NUM_WARPS-1:0]          dec_ready_warp;
    logic [NUM_WARPS-1:0]          eu_valid_warp;

    // Arbiter interface
    logic [NUM_WARPS-1:0]          offer_valid;
    logic [NUM_WARPS-1:0]          arb_gnt;
    disp_entry_t [NUM_WARPS-1:0]   offer;
    disp_entry_t                   arb_data;
    wid_t                          arb_idx;

    // ##############################
    // Demultiplexers
    // ##############################

    always_comb begin
        fe_hs_warp                 = '0;
        fe_hs_warp[fe_warp_id_i]   = fe_handshake_i;
        dec_valid_warp                = '0;
        dec_valid_warp[dec_warp_id_i] = dec_valid_i;
        // Lower id field names the warp
        eu_valid_warp               = '0;
        eu_valid_warp[eu_tag_i.wid] = eu_valid_i;
    end

    // Ready of the warp the decoder points at
    assign ib_ready_o = dec_ready_warp[dec_warp_id_i];

    // ##############################
    // Dispatchers
    // ##############################

    for (genvar w = 0; w < NUM_WARPS; w++) begin : gen_warp
        warp_dispatcher i_dispatcher (
            .clk_i          (clk_i),
            .reset_i        (reset_i),
            .fe_handshake_i (fe_hs_warp[w]),
            .space_avail_o  (ib_space_available_o[w]),
            .dec_valid_i    (dec_valid_warp[w]),
            .dec_ready_o    (dec_ready_warp[w]),
            .dec_inst_i     (dec_inst_i),
            .grant_i        (arb_gnt[w]),
            .offer_valid_o  (offer_valid[w]),
            .offer_o        (offer[w]),
            .eu_valid_i     (eu_valid_warp[w]),
            .eu_tag_i       (eu_tag_i.tag)
        );
    end

    // ##############################
    // Arbiter and issue
    // ##############################

    issue_rr_arbiter #(
        .DATA_T (disp_entry_t)
    ) i_arbiter (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (offer_valid),
        .data_i  (offer),
        .gnt_o   (arb_gnt),
        .valid_o (disp_valid_o),
        .ready_i (opc_ready_i),
        .data_o  (arb_data),
        .idx_o   (arb_idx)
    );

    // Instruction id from per-warp tag and winning warp
    assign disp_o.iid.tag = arb_data.tag;
    assign disp_o.iid.wid = arb_idx;
    assign disp_o.dec     = arb_data.dec;

endmodule

// File: tb_multi_warp_dispatcher.sv
/* Multi-warp dispatcher testbench
   Models fetcher, decoder, operand collector and execution units around the DUT */

`timescale 1ns/1ps

`include "bgpu_cfg.svh"

module tb_multi_warp_dispatcher import bgpu_pkg::*; ();

    localparam int NW          = `BGPU_NUM_WARPS;
    localparam int NT          = `BGPU_NUM_TAGS;
    localparam int DEPTH       = `BGPU_WAIT_BUF_DEPTH;
    localparam int RAND_CYCLES = 800;
    localparam real TIMEOUT_NS = (16.0 + RAND_CYCLES + 1000.0) * 40.0 * 2.0;

    // Traffic modes
    localparam int M_IDLE = 0;
    localparam int M_RAND = 1;
    localparam int M_QUIET = 2;
    localparam int M_FILL = 3;
    localparam int M_FAIR = 4;

    logic clk_i = 1'b0;
    logic reset_i;
    logic fe_handshake_i;
    wid_t fe_warp_id_i;
    logic [NW-1:0] ib_space_available_o;
    logic dec_valid_i;
    wid_t dec_warp_id_i;
    dec_inst_t dec_inst_i;
    logic ib_ready_o;
    logic disp_valid_o;
    disp_inst_t disp_o;
    logic opc_ready_i;
    logic eu_valid_i;
    iid_t eu_tag_i;

    int seed = 32'he0c5119a;
    int err_cnt = 0;
    int mode = M_IDLE;
    int written = 0;
    int issued = 0;
    int fair_cnt = 0;
    int last_wid = 0;

    // Stimulus side bookkeeping
    int slot_cnt [NW];
    int res_cnt [NW];
    int pc_cnt [NW];
    int fill_dst [NW];
    // Reservations plus unissued entries as the DUT holds them
    int acc_cnt [NW];
    // Written, not yet issued, in write order
    dec_inst_t wq [NW][$];
    // In-flight instructions
    logic inf_busy [NW][NT];
    reg_idx_t inf_dst [NW][NT];
    int inf_delay [NW][NT];

    always #20 clk_i = ~clk_i;

    multi_warp_dispatcher UUT (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .fe_handshake_i       (fe_handshake_i),
        .fe_warp_id_i         (fe_warp_id_i),
        .ib_space_available_o (ib_space_available_o),
        .dec_valid_i          (dec_valid_i),
        .dec_warp_id_i        (dec_warp_id_i),
        .dec_inst_i           (dec_inst_i),
        .ib_ready_o           (ib_ready_o),
        .disp_valid_o         (disp_valid_o),
        .disp_o               (disp_o),
        .opc_ready_i          (opc_ready_i),
        .eu_valid_i           (eu_valid_i),
        .eu_tag_i             (eu_tag_i)
    );

    // True when b must stay behind the older a
    function automatic logic order_conflict(dec_inst_t a, dec_inst_t b);
        logic c;
        c = (a.dst == b.dst);
        for (int k = 0; k < `BGPU_OPERANDS; k++) begin
            if (b.operands_required[k] && b.operands[k] == a.dst) c = 1'b1;
            if (a.operands_required[k] && a.operands[k] == b.dst) c = 1'b1;
        end
        return c;
    endfunction

    function automatic logic all_drained();
        logic d;
        d = 1'b1;
        for (int w = 0; w < NW; w++) begin
            if (res_cnt[w] != 0 || wq[w].size() != 0) d = 1'b0;
            for (int t = 0; t < NT; t++) begin
                if (inf_busy[w][t]) d = 1'b0;
            end
        end
        return d;
    endfunction

    // ##############################
    // Concurrent checks
    // ##############################

    assert property (@(posedge clk_i) $fell(reset_i) |->
        !disp_valid_o && (&ib_space_available_o) && ib_ready_o)
    else begin
        err_cnt++;
        $display("mismatch reset: disp_valid_o %h ib_space_available_o %h ib_ready_o %h",
                 disp_valid_o, ib_space_available_o, ib_ready_o);
        $display("  expected disp_valid_o 0 ib_space_available_o %h ib_ready_o 1",
                 {NW{1'b1}});
    end

    assert property (@(posedge clk_i) disable iff (reset_i) dec_valid_i |-> ib_ready_o)
    else begin
        err_cnt++;
        $display("mismatch ib_ready_o: got 0 expected 1");
    end

    for (genvar w = 0; w < NW; w++) begin : gen_slot_chk
        assert property (@(posedge clk_i) disable iff (reset_i)
            ib_space_available_o[w] == (acc_cnt[w] != DEPTH))
        else begin
            err_cnt++;
            $display("mismatch ib_space_available_o[%0d]: got %h expected %h",
                     w, ib_space_available_o[w], acc_cnt[w] != DEPTH);
        end

        // Fetcher reserves only while the warp shows space
        assert property (@(posedge clk_i) disable iff (reset_i)
            fe_handshake_i && fe_warp_id_i == wid_t'(w) |-> ib_space_available_o[w])
        else begin
            err_cnt++;
            $display("warp %0d reserved a slot while its space bit was low", w);
        end
    end

    // ##############################
    // Monitor and external unit models
    // ##############################

    always @(posedge clk_i) begin : model
        int w;
        int t;
        int m;
        int n_inf;
        int idx;
        logic hit;
        logic hs;
        dec_inst_t d;
        if (!reset_i) begin
            // Issue seen by the operand collector
            hs = fe_handshake_i;
            for (int v = 0; v < NW; v++) begin
                acc_cnt[v] <= acc_cnt[v] + int'(hs && fe_warp_id_i == wid_t'(v))
                              - int'(disp_valid_o && opc_ready_i && disp_o.iid.wid == wid_t'(v));
            end
            if (disp_valid_o && opc_ready_i) begin
                w = int'(disp_o.iid.wid);
                t = int'(disp_o.iid.tag);
                d = disp_o.dec;
                issued++;
                slot_cnt[w]--;
                n_inf = 0;
                assert (!inf_busy[w][t]) else begin
                    err_cnt++;
                    $display("tag %0d of warp %0d issued while still in flight", t, w);
                end
                for (int u = 0; u < NT; u++) begin
                    if (inf_busy[w][u]) begin
                        n_inf++;
                        hit = (inf_dst[w][u] == d.dst);
                        for (int k = 0; k < `BGPU_OPERANDS; k++) begin
                            if (d.operands_required[k] && d.operands[k] == inf_dst[w][u]) begin
                                hit = 1'b1;
                            end
                        end
                        assert (!hit) else begin
                            err_cnt++;
                            $display("warp %0d issued pc %h against in-flight r%0d",
                                     w, d.pc, inf_dst[w][u]);
                        end
                    end
                end
                assert (n_inf < NT) else begin
                    err_cnt++;
                    $display("warp %0d issued with all tags in flight", w);
                end
                m = -1;
                for (int j = 0; j < wq[w].size(); j++) begin
                    if (m < 0 && wq[w][j] == d) m = j;
                end
                assert (m >= 0) else begin
                    err_cnt++;
                    $display("mismatch disp_o.dec: %h of warp %0d matches no written entry", d, w);
                end
                if (m >= 0) begin
                    for (int j = 0; j < m; j++) begin
                        assert (!order_conflict(wq[w][j], d)) else begin
                            err_cnt++;
                            $display("warp %0d pc %h passed older conflicting pc %h",
                                     w, d.pc, wq[w][j].pc);
                        end
                    end
                    wq[w].delete(m);
                end
                inf_busy[w][t]  = 1'b1;
                inf_dst[w][t]   = d.dst;
                inf_delay[w][t] = 1 + ($random(seed) & 7);
                // Round-robin order while every warp offers
                if (mode == M_FAIR) begin
                    assert (fair_cnt == 0 || w == (last_wid + 1) % NW) else begin
                        err_cnt++;
                        $display("mismatch disp_o.iid.wid: got %h expected %h",
                                 w, (last_wid + 1) % NW);
                    end
                    fair_cnt++;
                    last_wid = w;
                end
            end

            // Writeback taken by the DUT at this edge
            if (eu_valid_i) begin
                inf_busy[eu_tag_i.wid][eu_tag_i.tag] = 1'b0;
            end

            fe_handshake_i <= 1'b0;
            dec_valid_i    <= 1'b0;
            eu_valid_i     <= 1'b0;

            // Decoder uses only reservations made in earlier cycles
            idx = $random(seed) & 3;
            hit = 1'b0;
            for (int k = 0; k < NW; k++) begin
                w = (idx + k) % NW;
                if (!hit && res_cnt[w] > 0) begin
                    hit = 1'b1;
                    d.pc                = {wid_t'(w), 14'(pc_cnt[w])};
                    d.act_mask          = act_mask_t'($random(seed));
                    d.inst              = bgpu_inst_t'($random(seed));
                    if (mode == M_FILL) begin
                        d.dst               = reg_idx_t'(16 + fill_dst[w]);
                        d.operands_required = '0;
                        fill_dst[w]++;
                    end else begin
                        d.dst               = reg_idx_t'($random(seed) & 7);
                        d.operands_required = 2'($random(seed));
                    end
                    d.operands[0] = reg_idx_t'($random(seed) & 7);
                    d.operands[1] = reg_idx_t'($random(seed) & 7);
                    pc_cnt[w]++;
                    res_cnt[w]--;
                    written++;
                    wq[w].push_back(d);
                    dec_valid_i   <= 1'b1;
                    dec_warp_id_i <= wid_t'(w);
                    dec_inst_i    <= d;
                end
            end

            // Fetcher
            if (mode == M_RAND && ($random(seed) & 1)) begin
                w = $random(seed) & 3;
                if (ib_space_available_o[w] && slot_cnt[w] < DEPTH) begin
                    slot_cnt[w]++;
                    res_cnt[w]++;
                    fe_handshake_i <= 1'b1;
                    fe_warp_id_i   <= wid_t'(w);
                end
            end else if (mode == M_FILL) begin
                hit = 1'b0;
                for (int v = 0; v < NW; v++) begin
                    if (!hit && slot_cnt[v] < DEPTH && ib_space_available_o[v]) begin
                        hit = 1'b1;
                        slot_cnt[v]++;
                        res_cnt[v]++;
                        fe_handshake_i <= 1'b1;
                        fe_warp_id_i   <= wid_t'(v);
                    end
                end
            end

            // Operand collector ready
            case (mode)
                M_RAND:  opc_ready_i <= ($random(seed) & 3) != 0;
                M_FILL:  opc_ready_i <= 1'b0;
                default: opc_ready_i <= 1'b1;
            endcase

            // Execution units, one writeback per cycle in any order
            for (int v = 0; v < NW; v++) begin
                for (int u = 0; u < NT; u++) begin
                    if (inf_busy[v][u] && inf_delay[v][u] > 0) inf_delay[v][u]--;
                end
            end
            if (mode != M_FILL && mode != M_FAIR) begin
                idx = $random(seed) & 15;
                hit = 1'b0;
                for (int k = 0; k < NW * NT; k++) begin
                    w = ((idx + k) % (NW * NT)) / NT;
                    t = ((idx + k) % (NW * NT)) % NT;
                    if (!hit && inf_busy[w][t] && inf_delay[w][t] == 0) begin
                        hit = 1'b1;
                        eu_valid_i   <= 1'b1;
                        eu_tag_i.tag <= tag_t'(t);
                        eu_tag_i.wid <= wid_t'(w);
                    end
                end
            end
        end
    end

    // ##############################
    // Sequence
    // ##############################

    initial begin
        logic full;
        reset_i        = 1'b1;
        fe_handshake_i = 1'b0;
        fe_warp_id_i   = '0;
        dec_valid_i    = 1'b0;
        dec_warp_id_i  = '0;
        dec_inst_i     = '0;
        opc_ready_i    = 1'b0;
        eu_valid_i     = 1'b0;
        eu_tag_i       = '0;
        for (int w = 0; w < NW; w++) begin
            slot_cnt[w] = 0;
            res_cnt[w]  = 0;
            pc_cnt[w]   = 0;
            fill_dst[w] = 0;
            acc_cnt[w]  = 0;
            for (int t = 0; t < NT; t++) begin
                inf_busy[w][t]  = 1'b0;
                inf_dst[w][t]   = '0;
                inf_delay[w][t] = 0;
            end
        end
        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;
        @(posedge clk_i);
        mode <= M_RAND;
        repeat (RAND_CYCLES) @(posedge clk_i);
        mode <= M_QUIET;
        @(posedge clk_i);
        while (!all_drained()) @(posedge clk_i);
        // Fill every buffer with independent entries
        repeat (4) @(posedge clk_i);
        mode <= M_FILL;
        full = 1'b0;
        while (!full) begin
            @(posedge clk_i);
            full = 1'b1;
            for (int w = 0; w < NW; w++) begin
                if (slot_cnt[w] != DEPTH || res_cnt[w] != 0) full = 1'b0;
            end
        end
        repeat (3) @(posedge clk_i);
        mode <= M_FAIR;
        while (fair_cnt < NW * DEPTH) @(posedge clk_i);
        mode <= M_QUIET;
        @(posedge clk_i);
        while (!all_drained()) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        for (int w = 0; w < NW; w++) begin
            assert (wq[w].size() == 0) else begin
                err_cnt++;
                $display("warp %0d kept %0d written instructions unissued", w, wq[w].size());
            end
        end
        $display("errors %0d, written %0d, issued %0d, fair issues %0d",
                 err_cnt, written, issued, fair_cnt);
        if (err_cnt == 0 && written == issued) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not reach its end");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
bgpu_pkg.sv
issue_scoreboard.sv
warp_dispatcher.sv
issue_rr_arbiter.sv
multi_warp_dispatcher.sv
tb_multi_warp_dispatcher.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_multi_warp_dispatcher

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" -f sim.f -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
else
    exit 1
fi
